// ==== memSubsys.f ====
logic/memPkg.sv
logic/byteRam.sv
logic/memCtrl.sv
logic/instFetch.sv
logic/loadStoreUnit.sv
logic/memTop.sv
sim/memTopTb.sv

// ==== build.sh ====
#!/bin/sh
# build the simulation with Verilator, run it and look for the pass message
cd "$(dirname "$0")" &&
verilator --binary --timing -f memSubsys.f --top-module memTopTb -o memTopTbSim &&
./obj_dir/memTopTbSim | tee /dev/stderr | grep "Simulation PASSED" > /dev/null &&
echo "run ok" ||
{ echo "run failed"; exit 1; }

// ==== sim/memTopTb.sv ====
`timescale 1ns/10ps

module memTopTb import memPkg::*; ();

    localparam int   ramBits   = 12;
    localparam int   ramSize   = 1 << ramBits;
    localparam addrT startPc   = 32'h0;
    localparam int   waitLimit = 1000;

    typedef logic [ramBits-1:0] ramIdxT;

    logic   clk;
    logic   rst;
    logic   rdy = 1'b1;
    logic   ioBufferFull = 1'b0;
    logic   pcSet;
    addrT   pcNew;
    logic   instValid;
    wordT   inst;
    addrT   instPc;
    logic   instReady;
    logic   lsReq;
    logic   lsStore;
    lsSizeT lsSize;
    logic   lsSigned;
    addrT   lsAddr;
    wordT   lsWdata;
    logic   lsBusy;
    logic   lsDone;
    wordT   lsRdata;

    // what the RAM should hold
    byteT shadow [ramSize];

    int   seed = 32'h854041de;
    int   stallSeed;
    int   errors;
    int   checks;
    logic fetchCheckOn;
    logic stallOn = 1'b0;
    logic loadPending;
    wordT expLoad;
    addrT expPc;

    memTop #(
        .ramAddrBits (ramBits),
        .resetPc     (startPc)
    ) memTop_inst (
        .clk          (clk),
        .rst          (rst),
        .rdy          (rdy),
        .ioBufferFull (ioBufferFull),
        .pcSet        (pcSet),
        .pcNew        (pcNew),
        .instValid    (instValid),
        .inst         (inst),
        .instPc       (instPc),
        .instReady    (instReady),
        .lsReq        (lsReq),
        .lsStore      (lsStore),
        .lsSize       (lsSize),
        .lsSigned     (lsSigned),
        .lsAddr       (lsAddr),
        .lsWdata      (lsWdata),
        .lsBusy       (lsBusy),
        .lsDone       (lsDone),
        .lsRdata      (lsRdata)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic int byteCount(input lsSizeT sz);
        if (sz == sizeByte) begin
            return 1;
        end
        if (sz == sizeHalf) begin
            return 2;
        end
        return 4;
    endfunction

    // expected load result with bytes taken modulo the RAM depth
    function automatic wordT refLoad(input addrT a, input lsSizeT sz, input logic sg);
        wordT w;
        int   n;
        w = '0;
        n = byteCount(sz);
        for (int i = 0; i < n; i++) begin
            w[8*i +: 8] = shadow[ramIdxT'(a + addrT'(i))];
        end
        if (sg && n == 1) begin
            w = {{24{w[7]}}, w[7:0]};
        end else if (sg && n == 2) begin
            w = {{16{w[15]}}, w[15:0]};
        end
        return w;
    endfunction

    function automatic wordT fillWord(input addrT a);
        return (a * 32'h9e3779b1) ^ 32'h5bd1e995;
    endfunction

    task automatic writeShadow(input addrT a, input lsSizeT sz, input wordT d);
        for (int i = 0; i < byteCount(sz); i++) begin
            shadow[ramIdxT'(a + addrT'(i))] = d[8*i +: 8];
        end
    endtask

    task automatic checkWord(input string name, input wordT got, input wordT exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error at %0t: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic checkAddr(input string name, input addrT got, input addrT exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error at %0t: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic checkBit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error at %0t: %s is %b, expected %b", $time, name, got, exp);
        end
    endtask

    task automatic abortOnTimeout(input string what);
        $display("timeout: no %s within %0d cycles at %0t", what, waitLimit, $time);
        $display("Simulation FAILED");
        $finish;
    endtask

    // compare outputs in the middle of the cycle
    always @(negedge clk) begin
        if (!rst) begin
            if (lsDone && loadPending) begin
                checkWord("lsRdata", lsRdata, expLoad);
            end
            if (pcSet) begin
                expPc = pcNew;
            end else if (instValid && fetchCheckOn) begin
                checkAddr("instPc", instPc, expPc);
                checkWord("inst", inst, refLoad(expPc, sizeWord, 1'b0));
                if (instReady) begin
                    expPc = expPc + 32'd4;
                end
            end
        end
    end

    // random pauses on rdy and ioBufferFull
    always @(posedge clk) begin : stallGen
        int r;
        #1;
        if (stallOn) begin
            r = $random(stallSeed);
            rdy = (r[1:0] != 2'b00);
            ioBufferFull = (r[4:2] == 3'b000);
        end else begin
            rdy = 1'b1;
            ioBufferFull = 1'b0;
        end
    end

    task automatic doLs(input logic st, input lsSizeT sz, input logic sg,
                        input addrT a, input wordT wd);
        int cnt;
        if (st) begin
            writeShadow(a, sz, wd);
        end else begin
            expLoad = refLoad(a, sz, sg);
        end
        loadPending = !st;
        lsReq    = 1'b1;
        lsStore  = st;
        lsSize   = sz;
        lsSigned = sg;
        lsAddr   = a;
        lsWdata  = wd;
        @(posedge clk);
        #1;
        lsReq = 1'b0;
        cnt = 0;
        // busy from the accepting edge until the result is out
        while (!lsDone && cnt < waitLimit) begin
            checkBit("lsBusy", lsBusy, 1'b1);
            @(posedge clk);
            #1;
            cnt++;
        end
        if (!lsDone) begin
            abortOnTimeout("lsDone");
        end else begin
            checkBit("lsBusy", lsBusy, 1'b0);
        end
        // let the done cycle pass before the next request changes expLoad
        @(posedge clk);
        #1;
    endtask

    task automatic randomOp(input addrT a);
        int r;
        int sel;
        r   = $random(seed);
        sel = $unsigned(r) % 3;
        doLs(r[8], lsSizeT'(sel[1:0]), r[9], a, $random(seed));
    endtask

    task automatic waitInstValid();
        int cnt;
        cnt = 0;
        while (!instValid && cnt < waitLimit) begin
            @(posedge clk);
            #1;
            cnt++;
        end
        if (!instValid) begin
            abortOnTimeout("instValid");
        end
    endtask

    task automatic waitFetchPc(input addrT target);
        int cnt;
        cnt = 0;
        while (expPc != target && cnt < waitLimit) begin
            @(posedge clk);
            #1;
            cnt++;
        end
        if (expPc != target) begin
            abortOnTimeout("fetch up to the target pc");
        end
    endtask

    task automatic reportTest(input string name, input int errBefore);
        if (errors == errBefore) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, errors - errBefore);
        end
    endtask

    task automatic runRoundTrip();
        wordT wd;
        addrT a;
        for (int s = 0; s < 3; s++) begin
            for (int off = 0; off < 4; off++) begin
                for (int k = 0; k < 2; k++) begin
                    a  = 32'h900 + addrT'(8 * s + off);
                    wd = $random(seed);
                    // second pass forces the sign bits on
                    if (k == 1) begin
                        wd = wd | 32'h80808080;
                    end
                    doLs(1'b1, lsSizeT'(s), 1'b0, a, wd);
                    doLs(1'b0, lsSizeT'(s), 1'b0, a, '0);
                    doLs(1'b0, lsSizeT'(s), 1'b1, a, '0);
                end
            end
        end
    endtask

    task automatic runFetchSequence();
        for (int i = 0; i < 16; i++) begin
            doLs(1'b1, sizeWord, 1'b0, startPc + addrT'(4 * i), $random(seed));
        end
        // clear the word fetched before the program was written
        pcSet = 1'b1;
        pcNew = startPc;
        fetchCheckOn = 1'b1;
        @(posedge clk);
        #1;
        pcSet = 1'b0;
        waitInstValid();
        // buffer must hold still while the decoder stalls
        for (int i = 0; i < 12; i++) begin
            @(posedge clk);
            #1;
            checkBit("instValid", instValid, 1'b1);
        end
        instReady = 1'b1;
        waitFetchPc(startPc + 32'd64);
        instReady = 1'b0;
    endtask

    task automatic runRedirect();
        instReady = 1'b1;
        waitInstValid();
        // the next edge accepts it and the following fetch is in flight three edges later
        repeat (4) @(posedge clk);
        #1;
        pcSet = 1'b1;
        pcNew = 32'h200;
        @(posedge clk);
        #1;
        pcSet = 1'b0;
        waitFetchPc(32'h210);
    endtask

    task automatic runTraffic(input int count);
        addrT pcBefore;
        pcBefore = expPc;
        instReady = 1'b1;
        // data kept above the fetch window
        for (int i = 0; i < count; i++) begin
            randomOp(32'h800 + addrT'($unsigned($random(seed)) % 32'h7f0));
        end
        if (expPc == pcBefore) begin
            errors++;
            $display("fetch made no progress during data traffic");
        end
    endtask

    task automatic runRandomMix();
        addrT a;
        for (int i = 0; i < 200; i++) begin
            if (i % 25 == 0) begin
                a = addrT'(ramSize - 1 - (i / 25) % 4);
            end else begin
                a = addrT'($random(seed)) & 32'h0000ffff;
            end
            randomOp(a);
        end
    endtask

    initial begin
        int errBefore;
        rst          = 1'b1;
        pcSet        = 1'b0;
        pcNew        = '0;
        instReady    = 1'b0;
        lsReq        = 1'b0;
        lsStore      = 1'b0;
        lsSize       = sizeByte;
        lsSigned     = 1'b0;
        lsAddr       = '0;
        lsWdata      = '0;
        errors       = 0;
        checks       = 0;
        fetchCheckOn = 1'b0;
        loadPending  = 1'b0;
        expLoad      = '0;
        expPc        = startPc;
        stallSeed    = $random(seed);
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;

        for (int a = 0; a < ramSize; a += 4) begin
            doLs(1'b1, sizeWord, 1'b0, addrT'(a), fillWord(addrT'(a)));
        end

        errBefore = errors;
        runRoundTrip();
        reportTest("store load round trip", errBefore);

        errBefore = errors;
        runFetchSequence();
        reportTest("fetch sequence", errBefore);

        errBefore = errors;
        runRedirect();
        reportTest("redirect", errBefore);

        errBefore = errors;
        runTraffic(60);
        reportTest("fetch and data together", errBefore);

        errBefore = errors;
        stallOn = 1'b1;
        runTraffic(60);
        stallOn = 1'b0;
        // read back the data half to catch stray writes
        for (int a = 32'h800; a < ramSize; a += 4) begin
            doLs(1'b0, sizeWord, 1'b0, addrT'(a), '0);
        end
        reportTest("stalls", errBefore);

        instReady    = 1'b0;
        fetchCheckOn = 1'b0;
        errBefore    = errors;
        stallOn      = 1'b1;
        runRandomMix();
        stallOn      = 1'b0;
        reportTest("random mix", errBefore);

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// ==== logic/memTop.sv ====
`timescale 1ns/10ps

module memTop import memPkg::*; #(
    parameter int   ramAddrBits = 12,
    parameter addrT resetPc     = 32'h0
) (
    input  logic   clk,
    input  logic   rst,
    input  logic   rdy,
    input  logic   ioBufferFull,

    input  logic   pcSet,
    input  addrT   pcNew,
    output logic   instValid,
    output wordT   inst,
    output addrT   instPc,
    input  logic   instReady,

    input  logic   lsReq,
    input  logic   lsStore,
    input  lsSizeT lsSize,
    input  logic   lsSigned,
    input  addrT   lsAddr,
    input  wordT   lsWdata,
    output logic   lsBusy,
    output logic   lsDone,
    output wordT   lsRdata
);

    // fetch side
    logic infEn;
    addrT infAddr;
    logic infDone;
    wordT infInst;

    // data side
    logic dcEn;
    logic dcStore;
    lenT  dcLen;
    addrT dcAddr;
    wordT dcWdata;
    logic dcDone;
    wordT dcRdata;

    // RAM side
    addrT memAddr;
    logic memWe;
    byteT memWdata;
    byteT memRdata;

    memCtrl memCtrl_inst (
        .clk          (clk),
        .rst          (rst),
        .rdy          (rdy),
        .ioBufferFull (ioBufferFull),
        .infEn        (infEn),
        .infAddr      (infAddr),
        .infDone      (infDone),
        .infInst      (infInst),
        .dcEn         (dcEn),
        .dcStore      (dcStore),
        .dcLen        (dcLen),
        .dcAddr       (dcAddr),
        .dcWdata      (dcWdata),
        .dcDone       (dcDone),
        .dcRdata      (dcRdata),
        .memAddr      (memAddr),
        .memWe        (memWe),
        .memWdata     (memWdata),
        .memRdata     (memRdata)
    );

    instFetch #(
        .resetPc (resetPc)
    ) instFetch_inst (
        .clk       (clk),
        .rst       (rst),
        .pcSet     (pcSet),
        .pcNew     (pcNew),
        .instValid (instValid),
        .inst      (inst),
        .instPc    (instPc),
        .instReady (instReady),
        .infEn     (infEn),
        .infAddr   (infAddr),
        .infDone   (infDone),
        .infInst   (infInst)
    );

    loadStoreUnit loadStoreUnit_inst (
        .clk      (clk),
        .rst      (rst),
        .lsReq    (lsReq),
        .lsStore  (lsStore),
        .lsSigned (lsSigned),
        .lsSize   (lsSize),
        .lsAddr   (lsAddr),
        .lsWdata  (lsWdata),
        .lsBusy   (lsBusy),
        .lsDone   (lsDone),
        .lsRdata  (lsRdata),
        .dcEn     (dcEn),
        .dcStore  (dcStore),
        .dcLen    (dcLen),
        .dcAddr   (dcAddr),
        .dcWdata  (dcWdata),
        .dcDone   (dcDone),
        .dcRdata  (dcRdata)
    );

    byteRam #(
        .ramAddrBits (ramAddrBits)
    ) byteRam_inst (
        .clk      (clk),
        .memAddr  (memAddr),
        .memWe    (memWe),
        .memWdata (memWdata),
        .memRdata (memRdata)
    );

endmodule

// ==== logic/loadStoreUnit.sv ====
`timescale 1ns/10ps

module loadStoreUnit import memPkg::*; (
    input  logic   clk,
    input  logic   rst,

    input  logic   lsReq,
    input  logic   lsStore,
    input  logic   lsSigned,
    input  lsSizeT lsSize,
    input  addrT   lsAddr,
    input  wordT   lsWdata,
    output logic   lsBusy,
    output logic   lsDone,
    output wordT   lsRdata,

    output logic   dcEn,
    output logic   dcStore,
    output lenT    dcLen,
    output addrT   dcAddr,
    output wordT   dcWdata,
    input  logic   dcDone,
    input  wordT   dcRdata
);

    logic signedReg;
    logic accept;
    logic finish;
    wordT loadExt;

    function automatic lenT sizeToLen(input lsSizeT size);
        case (size)
            sizeByte: return 3'd1;
            sizeHalf: return 3'd2;
            default:  return 3'd4;
        endcase
    endfunction

    assign accept = lsReq && !lsBusy;
    assign finish = dcEn && dcDone;

    // upper bytes arrive zeroed, only the signed case needs work
    always_comb begin
        case (dcLen)
            3'd1: begin
                loadExt = signedReg ? {{24{dcRdata[7]}}, dcRdata[7:0]} : dcRdata;
            end
            3'd2: begin
                loadExt = signedReg ? {{16{dcRdata[15]}}, dcRdata[15:0]} : dcRdata;
            end
            default: begin
                loadExt = dcRdata;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            lsBusy <= 1'b0;
            lsDone <= 1'b0;
            dcEn   <= 1'b0;
        end else begin
            lsDone <= finish;
            if (finish) begin
                dcEn   <= 1'b0;
                lsBusy <= 1'b0;
            end else if (accept) begin
                dcEn   <= 1'b1;
                lsBusy <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            dcStore   <= lsStore;
            dcLen     <= sizeToLen(lsSize);
            dcAddr    <= lsAddr;
            dcWdata   <= lsWdata;
            signedReg <= lsSigned;
        end
        // stores leave the last load result in place
        if (finish && !dcStore) begin
            lsRdata <= loadExt;
        end
    end

endmodule

// ==== logic/instFetch.sv ====
`timescale 1ns/10ps

module instFetch import memPkg::*; #(
    parameter addrT resetPc = 32'h0
) (
    input  logic clk,
    input  logic rst,

    input  logic pcSet,
    input  addrT pcNew,
    output logic instValid,
    output wordT inst,
    output addrT instPc,
    input  logic instReady,

    output logic infEn,
    output addrT infAddr,
    input  logic infDone,
    input  wordT infInst
);

    addrT pc;
    logic discard;
    logic fetchEnd;
    logic accepted;

    assign fetchEnd = infEn && infDone;
    assign accepted = instValid && instReady;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc        <= resetPc;
            infEn     <= 1'b0;
            instValid <= 1'b0;
            discard   <= 1'b0;
        end else begin
            if (fetchEnd) begin
                infEn   <= 1'b0;
                discard <= 1'b0;
                // a redirect since the fetch started makes this word stale
                if (!discard && !pcSet) begin
                    instValid <= 1'b1;
                end
            end else if (!infEn && !instValid && !pcSet) begin
                infEn <= 1'b1;
            end

            if (pcSet) begin
                pc        <= pcNew;
                instValid <= 1'b0;
                if (infEn && !infDone) begin
                    discard <= 1'b1;
                end
            end else if (accepted) begin
                instValid <= 1'b0;
                pc        <= pc + 32'd4;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!infEn && !instValid && !pcSet) begin
            infAddr <= pc;
        end
        if (fetchEnd) begin
            inst   <= infInst;
            instPc <= infAddr;
        end
    end

endmodule

// ==== logic/memCtrl.sv ====
`timescale 1ns/10ps

module memCtrl import memPkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     rdy,
    input  logic     ioBufferFull,

    input  logic     infEn,
    input  addrT     infAddr,
    output logic     infDone,
    output wordT     infInst,

    input  logic     dcEn,
    input  logic     dcStore,
    input  lenT      dcLen,
    input  addrT     dcAddr,
    input  wordT     dcWdata,
    output logic     dcDone,
    output wordT     dcRdata,

    output addrT     memAddr,
    output logic     memWe,
    output byteT     memWdata,
    input  byteT     memRdata
);

    memStateT state;
    lenT      stage;
    lenT      len;
    addrT     curAddr;
    addrT     prevAddr;
    wordT     wdataReg;
    wordT     rdBuf;
    wordT     rdShifted;
    wordT     rdWord;
    lenT      padBytes;
    logic     advance;
    logic     reading;
    logic     lastRead;
    logic     lastWrite;

    // everything holds while the CPU is not ready or the I/O buffer is full
    assign advance = rdy && !ioBufferFull;

    assign reading   = (state == stReadInst) || (state == stReadData);
    assign lastRead  = reading && (stage == len);
    assign lastWrite = (state == stWriteData) && (stage == len - 3'd1);

    // during a stall the previous address is kept on the RAM,
    // so the byte already in flight is still there afterwards
    assign memAddr  = advance ? curAddr : prevAddr;
    assign memWe    = advance && (state == stWriteData);
    assign memWdata = wdataReg[7:0];

    // last byte comes straight from the RAM, the rest from the buffer
    assign rdShifted = {memRdata, rdBuf[31:8]};
    assign padBytes  = fetchLen - len;
    assign rdWord    = rdShifted >> {padBytes, 3'b000};

    assign infInst = rdWord;
    assign dcRdata = rdWord;

    assign infDone = advance && (state == stReadInst) && lastRead;
    assign dcDone  = advance && (((state == stReadData) && lastRead) || lastWrite);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= stIdle;
            stage <= '0;
        end else if (advance) begin
            case (state)
                stIdle: begin
                    stage <= '0;
                    // data side wins over fetch
                    if (dcEn) begin
                        state <= dcStore ? stWriteData : stReadData;
                    end else if (infEn) begin
                        state <= stReadInst;
                    end
                end
                stReadInst, stReadData: begin
                    if (lastRead) begin
                        state <= stIdle;
                    end else begin
                        stage <= stage + 3'd1;
                    end
                end
                stWriteData: begin
                    if (lastWrite) begin
                        state <= stIdle;
                    end else begin
                        stage <= stage + 3'd1;
                    end
                end
                default: begin
                    state <= stIdle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        prevAddr <= memAddr;
        if (advance) begin
            if (state == stIdle) begin
                rdBuf <= '0;
                if (dcEn) begin
                    curAddr  <= dcAddr;
                    len      <= dcLen;
                    wdataReg <= dcWdata;
                end else begin
                    curAddr <= infAddr;
                    len     <= fetchLen;
                end
            end else begin
                curAddr  <= curAddr + 32'd1;
                // next byte to write moves into the low lane
                wdataReg <= wdataReg >> 8;
                // nothing has returned yet at stage 0
                if (stage != 3'd0) begin
                    rdBuf <= rdShifted;
                end
            end
        end
    end

endmodule

// ==== logic/byteRam.sv ====
`timescale 1ns/10ps

module byteRam import memPkg::*; #(
    parameter int ramAddrBits = 12
) (
    input  logic clk,
    input  addrT memAddr,
    input  logic memWe,
    input  byteT memWdata,
    output byteT memRdata
);

    localparam int depth = 1 << ramAddrBits;

    byteT                   mem [depth];
    logic [ramAddrBits-1:0] index;

    // addresses wrap at the top of the RAM
    assign index = memAddr[ramAddrBits-1:0];

    always_ff @(posedge clk) begin
        if (memWe) begin
            mem[index] <= memWdata;
        end
        memRdata <= mem[index];
    end

endmodule

// ==== logic/memPkg.sv ====
package memPkg;

    // byte address
    typedef logic [31:0] addrT;

    // instruction or data word
    typedef logic [31:0] wordT;

    // one RAM byte
    typedef logic [7:0] byteT;

    // bytes in one transfer, 1, 2 or 4
    typedef logic [2:0] lenT;

    typedef enum logic [1:0] {
        sizeByte,
        sizeHalf,
        sizeWord
    } lsSizeT;

    typedef enum logic [1:0] {
        stIdle,
        stReadInst,
        stReadData,
        stWriteData
    } memStateT;

    // an instruction is always four bytes
    localparam lenT fetchLen = 3'd4;

endpackage
